//--- hw/core_pkg.sv
// core_pkg
// Shared widths, word types and RV32I encodings for the four-stage core.
// Operation enums carry decode results from dec down to alu and dmem_ctrl.

`default_nettype none

package core_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int INSTR_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int NUM_REGS = 32;
	localparam int STRB_WIDTH = 4;	// one strobe per byte lane

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [INSTR_WIDTH-1:0] instr_t;
	typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// major opcodes
	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_JALR = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;	// srl or sra, picked by bit 30
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// funct3 for conditional branches
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;
	localparam logic [2:0] F3_BLT = 3'b100;
	localparam logic [2:0] F3_BGE = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
	} branch_op_t;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

	localparam instr_t NOP_INSTR = 32'h0000_0013;	// addi x0, x0, 0

endpackage

`default_nettype wire

//--- hw/fetch.sv
// fetch
// Program counter and instruction TCM requester. One request in flight at
// a time; the returned word sits in a one-entry buffer until dec takes it.
// A redirect retargets the pc and drops any response still in flight.

`timescale 1ns/1ps
`default_nettype none

module fetch (
	input  wire cpu_clk,
	input  wire reset,
	input  wire core_pkg::addr_t boot_addr,
	input  wire redirect,
	input  wire core_pkg::addr_t redirect_pc,
	output logic instr_itcm_access,
	output core_pkg::addr_t instr_itcm_addr,
	input  wire core_pkg::data_t instr_itcm_read_data,
	input  wire instr_itcm_read_data_valid,
	output logic if_valid,
	output core_pkg::instr_t instr_dec,
	output core_pkg::addr_t pc_dec,
	input  wire dec_ready
);

	core_pkg::addr_t pc;		// address of the current or next request
	logic outstanding;		// request issued, response not yet back
	logic kill;			// in-flight response is from a flushed path
	logic buf_valid;
	core_pkg::instr_t buf_instr;
	core_pkg::addr_t buf_pc;
	logic take_resp;

	assign instr_itcm_access = !outstanding && !buf_valid && !redirect;
	assign instr_itcm_addr = pc;
	assign take_resp = instr_itcm_read_data_valid && !kill && !redirect;

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			pc <= boot_addr;
			outstanding <= 1'b0;
			kill <= 1'b0;
		end else begin
			if (instr_itcm_access)
				outstanding <= 1'b1;
			else if (instr_itcm_read_data_valid)
				outstanding <= 1'b0;
			if (redirect) begin
				pc <= redirect_pc;
				kill <= outstanding && !instr_itcm_read_data_valid;
			end else begin
				if (instr_itcm_read_data_valid)
					kill <= 1'b0;
				if (take_resp)
					pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (reset || redirect)
			buf_valid <= 1'b0;
		else if (take_resp)
			buf_valid <= 1'b1;
		else if (dec_ready)
			buf_valid <= 1'b0;	// consumed by dec
	end

	always_ff @(posedge cpu_clk) begin
		if (take_resp) begin
			buf_instr <= instr_itcm_read_data;
			buf_pc <= pc;
		end
	end

	assign if_valid = buf_valid;
	assign instr_dec = buf_instr;
	assign pc_dec = buf_pc;

	// next request only once the previous response is back
	a_one_outstanding: assert property (@(posedge cpu_clk) disable iff (reset)
		instr_itcm_access |=> !instr_itcm_access until_with instr_itcm_read_data_valid);

	// redirect targets come from alu, which clears bit 0 only
	a_pc_aligned: assert property (@(posedge cpu_clk) disable iff (reset)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/dec.sv
// dec
// Decodes the buffered instruction, reads the register file and hands the
// operation to alu. A scoreboard of pending destinations holds an
// instruction in fetch's buffer until its sources and destination are free.

`timescale 1ns/1ps
`default_nettype none

module dec (
	input  wire cpu_clk,
	input  wire reset,
	input  wire if_valid,
	input  wire core_pkg::instr_t instr_dec,
	input  wire core_pkg::addr_t pc_dec,
	output logic dec_ready,
	input  wire redirect,
	output logic dec_valid,
	input  wire ex_ready,
	output core_pkg::addr_t pc_ex,
	output core_pkg::data_t src_data1_ex,
	output core_pkg::data_t src_data2_ex,
	output core_pkg::data_t imm_ex,
	output logic use_imm_ex,
	output core_pkg::alu_op_t alu_op_ex,
	output core_pkg::branch_op_t branch_op_ex,
	output logic jal_ex,
	output logic jalr_ex,
	output logic auipc_ex,
	output logic load_ex,
	output logic store_ex,
	output logic mem_unsigned_ex,
	output core_pkg::mem_size_t mem_size_ex,
	output core_pkg::reg_addr_t rd_ex,
	input  wire wb_valid,
	input  wire core_pkg::reg_addr_t wb_rd,
	input  wire core_pkg::data_t wb_data
);

	core_pkg::instr_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	core_pkg::reg_addr_t rs1, rs2, rd, rd_w;
	core_pkg::data_t imm_i, imm_s, imm_b, imm_u, imm_j, imm;
	core_pkg::data_t regs [1:core_pkg::NUM_REGS-1];	// x0 is not stored
	logic [core_pkg::NUM_REGS-1:0] pending, set_mask, clr_mask;
	logic uses_rs1, uses_rs2, writes_rd, hazard, accept;
	logic use_imm, jal, jalr, auipc, load, store;
	core_pkg::alu_op_t alu_op;
	core_pkg::branch_op_t branch_op;

	function automatic core_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			core_pkg::F3_ADD: alu_sel = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			core_pkg::F3_SLL: alu_sel = core_pkg::ALU_SLL;
			core_pkg::F3_SLT: alu_sel = core_pkg::ALU_SLT;
			core_pkg::F3_SLTU: alu_sel = core_pkg::ALU_SLTU;
			core_pkg::F3_XOR: alu_sel = core_pkg::ALU_XOR;
			core_pkg::F3_SR: alu_sel = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			core_pkg::F3_OR: alu_sel = core_pkg::ALU_OR;
			default: alu_sel = core_pkg::ALU_AND;
		endcase
	endfunction

	assign instr = if_valid ? instr_dec : core_pkg::NOP_INSTR;	// bubble when empty
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = imm_i;
		use_imm = 1'b0;
		alu_op = core_pkg::ALU_ADD;
		branch_op = core_pkg::BR_NONE;
		{jal, jalr, auipc, load, store} = '0;
		{uses_rs1, uses_rs2, writes_rd} = '0;
		case (opcode)
			core_pkg::OP_LUI: begin
				{imm, use_imm, writes_rd} = {imm_u, 2'b11};
				alu_op = core_pkg::ALU_PASS_B;
			end
			core_pkg::OP_AUIPC: {imm, use_imm, auipc, writes_rd} = {imm_u, 3'b111};
			core_pkg::OP_JAL: {imm, jal, writes_rd} = {imm_j, 2'b11};
			core_pkg::OP_JALR: {jalr, uses_rs1, writes_rd} = 3'b111;
			core_pkg::OP_BRANCH: begin
				{imm, uses_rs1, uses_rs2} = {imm_b, 2'b11};
				case (funct3)
					core_pkg::F3_BEQ: branch_op = core_pkg::BR_BEQ;
					core_pkg::F3_BNE: branch_op = core_pkg::BR_BNE;
					core_pkg::F3_BLT: branch_op = core_pkg::BR_BLT;
					core_pkg::F3_BGE: branch_op = core_pkg::BR_BGE;
					core_pkg::F3_BLTU: branch_op = core_pkg::BR_BLTU;
					core_pkg::F3_BGEU: branch_op = core_pkg::BR_BGEU;
					default: branch_op = core_pkg::BR_NONE;
				endcase
			end
			core_pkg::OP_LOAD: {use_imm, load, uses_rs1, writes_rd} = 4'b1111;
			core_pkg::OP_STORE: {imm, use_imm, store, uses_rs1, uses_rs2} = {imm_s, 4'b1111};
			core_pkg::OP_IMM: begin
				{use_imm, uses_rs1, writes_rd} = 3'b111;
				alu_op = alu_sel(funct3, instr[30] && funct3 == core_pkg::F3_SR);
			end
			core_pkg::OP_REG: begin
				{uses_rs1, uses_rs2, writes_rd} = 3'b111;
				alu_op = alu_sel(funct3, instr[30]);
			end
			default: ;	// fence, system and unknown run as no-ops
		endcase
	end

	assign rd_w = writes_rd ? rd : '0;
	assign hazard = (uses_rs1 && pending[rs1]) || (uses_rs2 && pending[rs2]) ||
		(writes_rd && pending[rd]);
	assign dec_ready = (!dec_valid || ex_ready) && !hazard;
	assign accept = if_valid && dec_ready && !redirect;

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (accept && rd_w != '0)
			set_mask[rd_w] = 1'b1;
		if (wb_valid)
			clr_mask[wb_rd] = 1'b1;
		if (redirect && dec_valid)
			clr_mask[rd_ex] = 1'b1;	// flushed op never writes back
	end

	always_ff @(posedge cpu_clk) begin
		if (reset)
			pending <= '0;
		else
			pending <= (pending & ~clr_mask) | set_mask;
	end

	always_ff @(posedge cpu_clk) begin
		if (wb_valid && wb_rd != '0)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge cpu_clk) begin
		if (reset)
			dec_valid <= 1'b0;
		else if (redirect || !dec_valid || ex_ready)
			dec_valid <= accept;
	end

	always_ff @(posedge cpu_clk) begin
		if (accept) begin
			pc_ex <= pc_dec;
			src_data1_ex <= (rs1 == '0) ? '0 : regs[rs1];
			src_data2_ex <= (rs2 == '0) ? '0 : regs[rs2];
			imm_ex <= imm;
			use_imm_ex <= use_imm;
			alu_op_ex <= alu_op;
			branch_op_ex <= branch_op;
			{jal_ex, jalr_ex, auipc_ex, load_ex, store_ex} <= {jal, jalr, auipc, load, store};
			mem_unsigned_ex <= funct3[2];
			mem_size_ex <= core_pkg::mem_size_t'(funct3[1:0]);
			rd_ex <= rd_w;
		end
	end

	// x0 is never marked, so every writeback retires a marked register
	a_wb_marked: assert property (@(posedge cpu_clk) disable iff (reset)
		wb_valid |-> wb_rd != '0 && pending[wb_rd]);

endmodule

`default_nettype wire

//--- hw/alu.sv
// alu
// Execute stage. Computes the ALU result or jump link address, resolves
// branches and jumps, and forms load/store addresses. The redirect fires
// when the taken branch or jump moves on into dmem_ctrl.

`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_clk,
	input  wire reset,
	input  wire dec_valid,
	output logic ex_ready,
	input  wire core_pkg::addr_t pc_ex,
	input  wire core_pkg::data_t src_data1_ex,
	input  wire core_pkg::data_t src_data2_ex,
	input  wire core_pkg::data_t imm_ex,
	input  wire use_imm_ex,
	input  wire core_pkg::alu_op_t alu_op_ex,
	input  wire core_pkg::branch_op_t branch_op_ex,
	input  wire jal_ex,
	input  wire jalr_ex,
	input  wire auipc_ex,
	input  wire load_ex,
	input  wire store_ex,
	input  wire mem_unsigned_ex,
	input  wire core_pkg::mem_size_t mem_size_ex,
	input  wire core_pkg::reg_addr_t rd_ex,
	output logic redirect,
	output core_pkg::addr_t redirect_pc,
	output logic ex_valid,
	input  wire mem_ready,
	output core_pkg::data_t result_mem,
	output core_pkg::data_t store_data_mem,
	output logic load_mem,
	output logic store_mem,
	output logic mem_unsigned_mem,
	output core_pkg::mem_size_t mem_size_mem,
	output core_pkg::reg_addr_t rd_mem
);

	core_pkg::data_t op_a, op_b, alu_res, target_sum;
	logic [4:0] shamt;
	logic eq, lt, ltu, taken;
	logic taken_q;
	core_pkg::addr_t target_q;

	assign op_a = auipc_ex ? pc_ex : src_data1_ex;
	assign op_b = use_imm_ex ? imm_ex : src_data2_ex;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op_ex)
			core_pkg::ALU_SUB: alu_res = op_a - op_b;
			core_pkg::ALU_SLT: alu_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			core_pkg::ALU_SLTU: alu_res = (op_a < op_b) ? 32'd1 : 32'd0;
			core_pkg::ALU_AND: alu_res = op_a & op_b;
			core_pkg::ALU_OR: alu_res = op_a | op_b;
			core_pkg::ALU_XOR: alu_res = op_a ^ op_b;
			core_pkg::ALU_SLL: alu_res = op_a << shamt;
			core_pkg::ALU_SRL: alu_res = op_a >> shamt;
			core_pkg::ALU_SRA: alu_res = core_pkg::data_t'($signed(op_a) >>> shamt);
			core_pkg::ALU_PASS_B: alu_res = op_b;	// lui
			default: alu_res = op_a + op_b;
		endcase
	end

	// branch compare always uses the two register operands
	assign eq = src_data1_ex == src_data2_ex;
	assign lt = $signed(src_data1_ex) < $signed(src_data2_ex);
	assign ltu = src_data1_ex < src_data2_ex;

	always_comb begin
		case (branch_op_ex)
			core_pkg::BR_BEQ: taken = eq;
			core_pkg::BR_BNE: taken = !eq;
			core_pkg::BR_BLT: taken = lt;
			core_pkg::BR_BGE: taken = !lt;
			core_pkg::BR_BLTU: taken = ltu;
			core_pkg::BR_BGEU: taken = !ltu;
			default: taken = jal_ex || jalr_ex;
		endcase
	end

	assign target_sum = (jalr_ex ? src_data1_ex : pc_ex) + imm_ex;

	assign ex_ready = !ex_valid || mem_ready;
	assign redirect = ex_valid && mem_ready && taken_q;
	assign redirect_pc = target_q;

	always_ff @(posedge cpu_clk) begin
		if (reset)
			ex_valid <= 1'b0;
		else if (ex_ready)
			ex_valid <= dec_valid && !redirect;	// younger op dies on redirect
	end

	always_ff @(posedge cpu_clk) begin
		if (ex_ready && dec_valid) begin
			result_mem <= (jal_ex || jalr_ex) ? pc_ex + 32'd4 : alu_res;
			store_data_mem <= src_data2_ex;
			load_mem <= load_ex;
			store_mem <= store_ex;
			mem_unsigned_mem <= mem_unsigned_ex;
			mem_size_mem <= mem_size_ex;
			rd_mem <= rd_ex;
			taken_q <= taken;
			target_q <= {target_sum[31:1], 1'b0};
		end
	end

endmodule

`default_nettype wire

//--- hw/dmem_ctrl.sv
// dmem_ctrl
// Memory and writeback stage. Drives DTCM requests with byte strobes and
// lane-shifted store data, waits for ready and then for read data, and
// aligns and extends loads. All results are written back to dec from here.

`timescale 1ns/1ps
`default_nettype none

module dmem_ctrl (
	input  wire cpu_clk,
	input  wire reset,
	input  wire ex_valid,
	output logic mem_ready,
	input  wire core_pkg::data_t result_mem,
	input  wire core_pkg::data_t store_data_mem,
	input  wire load_mem,
	input  wire store_mem,
	input  wire mem_unsigned_mem,
	input  wire core_pkg::mem_size_t mem_size_mem,
	input  wire core_pkg::reg_addr_t rd_mem,
	output logic data_dtcm_access,
	input  wire data_dtcm_ready,
	output logic data_dtcm_rd0_wr1,
	output core_pkg::strb_t data_dtcm_byte_strobe,
	output core_pkg::data_t data_dtcm_write_data,
	output core_pkg::addr_t data_dtcm_addr,
	input  wire core_pkg::data_t data_dtcm_read_data,
	input  wire data_dtcm_read_data_valid,
	output logic wb_valid,
	output core_pkg::reg_addr_t wb_rd,
	output core_pkg::data_t wb_data
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_RESP} state_t;

	state_t state;
	logic accept, load_done;
	logic [1:0] offset;		// byte lane of the access
	core_pkg::mem_size_t size_q;
	logic unsigned_q;
	core_pkg::strb_t strb;
	core_pkg::data_t shifted, load_val;

	assign mem_ready = state == S_IDLE;
	assign accept = ex_valid && mem_ready;
	assign data_dtcm_access = state == S_REQ;
	assign load_done = state == S_RESP && data_dtcm_read_data_valid;

	always_comb begin
		case (mem_size_mem)
			core_pkg::MEM_BYTE: strb = 4'b0001 << result_mem[1:0];
			core_pkg::MEM_HALF: strb = 4'b0011 << {result_mem[1], 1'b0};
			default: strb = 4'b1111;
		endcase
	end

	assign shifted = data_dtcm_read_data >> {offset, 3'b000};

	always_comb begin
		case (size_q)
			core_pkg::MEM_BYTE:
				load_val = unsigned_q ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
			core_pkg::MEM_HALF:
				load_val = unsigned_q ? {16'b0, shifted[15:0]} :
					{{16{shifted[15]}}, shifted[15:0]};
			default: load_val = shifted;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			state <= S_IDLE;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;	// single cycle write pulse
			case (state)
				S_IDLE:
					if (accept) begin
						if (load_mem || store_mem)
							state <= S_REQ;
						else
							wb_valid <= rd_mem != '0;
					end
				S_REQ:
					if (data_dtcm_ready)
						state <= data_dtcm_rd0_wr1 ? S_IDLE : S_RESP;	// store ends here
				S_RESP:
					if (data_dtcm_read_data_valid) begin
						state <= S_IDLE;
						wb_valid <= wb_rd != '0;
					end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (accept) begin
			data_dtcm_addr <= {result_mem[core_pkg::ADDR_WIDTH-1:2], 2'b00};
			data_dtcm_rd0_wr1 <= store_mem;
			data_dtcm_byte_strobe <= strb;
			data_dtcm_write_data <= store_data_mem << {result_mem[1:0], 3'b000};
			offset <= result_mem[1:0];
			size_q <= mem_size_mem;
			unsigned_q <= mem_unsigned_mem;
			wb_rd <= rd_mem;
			wb_data <= result_mem;
		end else if (load_done) begin
			wb_data <= load_val;
		end
	end

	// request held until the DTCM takes it
	a_req_stable: assert property (@(posedge cpu_clk) disable iff (reset)
		data_dtcm_access && !data_dtcm_ready |=> data_dtcm_access &&
			$stable(data_dtcm_addr) && $stable(data_dtcm_rd0_wr1) &&
			$stable(data_dtcm_byte_strobe) && $stable(data_dtcm_write_data));

endmodule

`default_nettype wire

//--- hw/core.sv
// core
// Top of the four-stage RV32I core: fetch, dec, alu and dmem_ctrl,
// joined by valid/ready levels, with the instruction and data TCM ports.

`timescale 1ns/1ps
`default_nettype none

module core (
	input  wire cpu_clk,
	input  wire reset,
	input  wire core_pkg::addr_t boot_addr,
	output wire instr_itcm_access,
	output wire core_pkg::addr_t instr_itcm_addr,
	input  wire core_pkg::data_t instr_itcm_read_data,
	input  wire instr_itcm_read_data_valid,
	output wire data_dtcm_access,
	input  wire data_dtcm_ready,
	output wire data_dtcm_rd0_wr1,
	output wire core_pkg::strb_t data_dtcm_byte_strobe,
	output wire core_pkg::data_t data_dtcm_write_data,
	output wire core_pkg::addr_t data_dtcm_addr,
	input  wire core_pkg::data_t data_dtcm_read_data,
	input  wire data_dtcm_read_data_valid
);

	// fetch to dec, and the redirect back from alu
	wire if_valid, dec_ready, redirect;
	wire core_pkg::instr_t instr_dec;
	wire core_pkg::addr_t pc_dec;
	wire core_pkg::addr_t redirect_pc;

	// dec to alu
	wire dec_valid, ex_ready;
	wire core_pkg::addr_t pc_ex;
	wire core_pkg::data_t src_data1_ex, src_data2_ex, imm_ex;
	wire use_imm_ex, jal_ex, jalr_ex, auipc_ex, load_ex, store_ex, mem_unsigned_ex;
	wire core_pkg::alu_op_t alu_op_ex;
	wire core_pkg::branch_op_t branch_op_ex;
	wire core_pkg::mem_size_t mem_size_ex;
	wire core_pkg::reg_addr_t rd_ex;

	// alu to dmem_ctrl
	wire ex_valid, mem_ready, load_mem, store_mem, mem_unsigned_mem;
	wire core_pkg::data_t result_mem, store_data_mem;
	wire core_pkg::mem_size_t mem_size_mem;
	wire core_pkg::reg_addr_t rd_mem;

	// writeback into the register file
	wire wb_valid;
	wire core_pkg::reg_addr_t wb_rd;
	wire core_pkg::data_t wb_data;

	fetch u_fetch (.*);

	dec u_dec (.*);

	alu u_alu (.*);

	dmem_ctrl u_dmem_ctrl (.*);

endmodule

`default_nettype wire

//--- tb/tb_core.sv
// tb_core
// Testbench for the four-stage RV32I core. Loads a program, a data preload
// and the expected store list from a vectors file, models both TCMs with
// pseudo-random latencies, checks every store and waits for the halt loop.

`timescale 1ns/1ps
`default_nettype none

module tb_core;

	localparam int MEM_WORDS = 256;
	localparam int MAX_STORES = 64;
	localparam int RESET_CYCLES = 5;
	localparam int FETCH_TIMEOUT = 20;
	localparam int HALT_TIMEOUT = 4000;
	localparam int HALT_FETCHES = 4;	// enough that the halt jal itself has run
	localparam core_pkg::addr_t BOOT_ADDR = 32'h0000_0100;

	logic cpu_clk;
	logic reset;
	core_pkg::addr_t boot_addr;
	logic instr_itcm_access;
	core_pkg::addr_t instr_itcm_addr;
	core_pkg::data_t instr_itcm_read_data = '0;
	logic instr_itcm_read_data_valid = 1'b0;
	logic data_dtcm_access;
	logic data_dtcm_ready = 1'b0;
	logic data_dtcm_rd0_wr1;
	core_pkg::strb_t data_dtcm_byte_strobe;
	core_pkg::data_t data_dtcm_write_data;
	core_pkg::addr_t data_dtcm_addr;
	core_pkg::data_t data_dtcm_read_data = '0;
	logic data_dtcm_read_data_valid = 1'b0;

	core_pkg::instr_t imem [0:MEM_WORDS-1];
	core_pkg::data_t dmem [0:MEM_WORDS-1];
	core_pkg::addr_t exp_addr [0:MAX_STORES-1];
	core_pkg::data_t exp_data [0:MAX_STORES-1];
	core_pkg::strb_t exp_strb [0:MAX_STORES-1];
	core_pkg::addr_t halt_addr = '1;
	int num_stores = 0;
	int store_idx = 0;
	int halt_fetches = 0;
	int value_errors = 0;
	int other_errors = 0;

	// state of both memory models and their latency generators
	int unsigned ifetch_seed = 39;
	int unsigned dtcm_seed = 39;
	logic ifetch_busy = 1'b0;
	int unsigned ifetch_wait;
	core_pkg::addr_t ifetch_addr;
	logic req_active = 1'b0;
	int unsigned ready_wait;
	logic rd_busy = 1'b0;
	int unsigned rd_wait;
	core_pkg::data_t rd_word;

	core core_inst (.*);

	initial begin
		cpu_clk = 1'b0;
		forever #20 cpu_clk = ~cpu_clk;
	end

	function automatic int unsigned next_delay(inout int unsigned state, input int unsigned span);
		state = state * 32'd1664525 + 32'd1013904223;
		return (state >> 16) % span;
	endfunction

	task automatic check_addr(input string name, input core_pkg::addr_t got,
		input core_pkg::addr_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_data(input string name, input core_pkg::data_t got,
		input core_pkg::data_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_strb(input string name, input core_pkg::strb_t got,
		input core_pkg::strb_t exp);
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		int i;
		string line;
		core_pkg::addr_t a;
		core_pkg::data_t d;
		logic [31:0] s;
		for (i = 0; i < MEM_WORDS; i++) begin
			imem[i] = core_pkg::NOP_INSTR | (i << 22);	// addi x0, x0 with its byte address
			dmem[i] = 32'hDA7A_0000 | (i << 2);	// byte address in the low half
		end
		fd = $fopen("tb/core_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vectors file tb/core_vectors.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, d, s);
					case (line[0])
						"I": imem[a[9:2]] = d;
						"M": dmem[a[9:2]] = d;
						"H": halt_addr = a;
						"S": begin
							exp_addr[num_stores] = a;
							exp_data[num_stores] = d;
							exp_strb[num_stores] = s[3:0];
							num_stores++;
						end
						default: ;
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// compare a store accepted this cycle, then apply it lane by lane
	task automatic take_store();
		core_pkg::data_t mask;
		int b;
		mask = '0;
		if (store_idx >= num_stores) begin
			$display("unexpected store to address %h after all expected stores", data_dtcm_addr);
			other_errors++;
		end else begin
			for (b = 0; b < core_pkg::STRB_WIDTH; b++)
				if (exp_strb[store_idx][b])
					mask[8*b +: 8] = 8'hFF;
			check_addr("data_dtcm_addr", data_dtcm_addr, exp_addr[store_idx]);
			check_data("data_dtcm_write_data", data_dtcm_write_data & mask,
				exp_data[store_idx] & mask);
			check_strb("data_dtcm_byte_strobe", data_dtcm_byte_strobe, exp_strb[store_idx]);
			store_idx++;
		end
		for (b = 0; b < core_pkg::STRB_WIDTH; b++)
			if (data_dtcm_byte_strobe[b])
				dmem[data_dtcm_addr[9:2]][8*b +: 8] = data_dtcm_write_data[8*b +: 8];
	endtask

	// instruction TCM answering 1 to 3 cycles after the request
	always @(negedge cpu_clk) begin
		instr_itcm_read_data_valid <= 1'b0;
		if (reset) begin
			ifetch_busy = 1'b0;
		end else if (ifetch_busy) begin
			if (ifetch_wait == 0) begin
				instr_itcm_read_data <= imem[ifetch_addr[9:2]];
				instr_itcm_read_data_valid <= 1'b1;
				ifetch_busy = 1'b0;
			end else begin
				ifetch_wait--;
			end
		end
		// a request seen in the last reset cycle is the first real one
		if (instr_itcm_access === 1'b1) begin
			ifetch_busy = 1'b1;
			ifetch_addr = instr_itcm_addr;
			ifetch_wait = next_delay(ifetch_seed, 3);
			if (instr_itcm_addr == halt_addr)
				halt_fetches++;
		end
	end

	// DTCM with ready after 0 to 2 cycles and read data 1 to 3 cycles later
	always @(negedge cpu_clk) begin
		data_dtcm_ready <= 1'b0;
		data_dtcm_read_data_valid <= 1'b0;
		if (reset) begin
			req_active = 1'b0;
			rd_busy = 1'b0;
		end else begin
			if (rd_busy) begin
				if (rd_wait == 0) begin
					data_dtcm_read_data <= rd_word;
					data_dtcm_read_data_valid <= 1'b1;
					rd_busy = 1'b0;
				end else begin
					rd_wait--;
				end
			end
			if (data_dtcm_access === 1'b1) begin
				if (!req_active) begin
					req_active = 1'b1;
					ready_wait = next_delay(dtcm_seed, 3);
				end
				if (ready_wait == 0) begin
					data_dtcm_ready <= 1'b1;	// taken at the next rising edge
					req_active = 1'b0;
					if (data_dtcm_rd0_wr1) begin
						take_store();
					end else begin
						rd_word = dmem[data_dtcm_addr[9:2]];
						rd_wait = next_delay(dtcm_seed, 3);
						rd_busy = 1'b1;
					end
				end else begin
					ready_wait--;
				end
			end
		end
	end

	initial begin : main
		int cycles;
		reset = 1'b1;
		boot_addr = BOOT_ADDR;
		load_vectors();
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		@(negedge cpu_clk);
		reset <= 1'b0;

		cycles = 0;
		while (instr_itcm_access !== 1'b1 && cycles < FETCH_TIMEOUT) begin
			@(negedge cpu_clk);
			cycles++;
		end
		if (instr_itcm_access !== 1'b1) begin
			$display("timeout: the core issued no instruction fetch after reset");
			other_errors++;
		end else begin
			check_addr("instr_itcm_addr", instr_itcm_addr, boot_addr);
			cycles = 0;
			while (halt_fetches < HALT_FETCHES && cycles < HALT_TIMEOUT) begin
				@(posedge cpu_clk);
				cycles++;
			end
			if (halt_fetches < HALT_FETCHES) begin
				$display("timeout: the program never settled in the halt loop at %h", halt_addr);
				other_errors++;
			end
		end

		if (store_idx < num_stores) begin
			$display("missing stores: only %0d of %0d expected stores were seen",
				store_idx, num_stores);
			other_errors++;
		end
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
hw/core_pkg.sv
hw/fetch.sv
hw/dec.sv
hw/alu.sv
hw/dmem_ctrl.sv
hw/core.sv
tb/tb_core.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/fetch.sv
      - hw/dec.sv
      - hw/alu.sv
      - hw/dmem_ctrl.sv
      - hw/core.sv
  - target: simulation
    files:
      - tb/tb_core.sv

//--- tb/core_vectors.txt
# I addr instr | M addr data | S addr data strobe (data only in strobed lanes)
# H addr of the jal x0,0 halt loop; all fields hex, text after the fields is ignored
I 00000100 123450b7  # lui   x1, 0x12345
I 00000104 67808093  # addi  x1, x1, 0x678
I 00000108 04102023  # sw    x1, 0x40(x0)
I 0000010c 00001117  # auipc x2, 0x1
I 00000110 04202223  # sw    x2, 0x44(x0)
I 00000114 ffb00193  # addi  x3, x0, -5
I 00000118 4011d213  # srai  x4, x3, 1
I 0000011c 001222b3  # slt   x5, x4, x1
I 00000120 40408333  # sub   x6, x1, x4
I 00000124 005343b3  # xor   x7, x6, x5
I 00000128 04702423  # sw    x7, 0x48(x0)
I 0000012c 00409413  # slli  x8, x1, 4
I 00000130 00546433  # or    x8, x8, x5
I 00000134 048006a3  # sb    x8, 0x4d(x0)
I 00000138 04301723  # sh    x3, 0x4e(x0)
I 0000013c 08000483  # lb    x9, 0x80(x0)
I 00000140 08205503  # lhu   x10, 0x82(x0)
I 00000144 08201583  # lh    x11, 0x82(x0)
I 00000148 08104603  # lbu   x12, 0x81(x0)
I 0000014c 04902823  # sw    x9, 0x50(x0)
I 00000150 04b02a23  # sw    x11, 0x54(x0)
I 00000154 00c506b3  # add   x13, x10, x12
I 00000158 04d02c23  # sw    x13, 0x58(x0)
I 0000015c 00029463  # bne   x5, x0, +8 taken
I 00000160 04102e23  # sw    x1, 0x5c(x0) skipped
I 00000164 00404463  # blt   x0, x4, +8 not taken
I 00000168 00c007ef  # jal   x15, +12
I 0000016c 04102e23  # sw    x1, 0x5c(x0) skipped
I 00000170 04102e23  # sw    x1, 0x5c(x0) skipped
I 00000174 04f02e23  # sw    x15, 0x5c(x0)
I 00000178 01478867  # jalr  x16, 0x14(x15)
I 0000017c 04102e23  # sw    x1, 0x5c(x0) skipped
I 00000180 07002023  # sw    x16, 0x60(x0)
I 00000184 00127463  # bgeu  x4, x1, +8 taken
I 00000188 04102e23  # sw    x1, 0x5c(x0) skipped
I 0000018c 0000006f  # jal   x0, 0
M 00000080 8001f0a5
S 00000040 12345678 f
S 00000044 0000110c f
S 00000048 1234567a f
S 0000004c 00008100 2
S 0000004c fffb0000 c
S 00000050 ffffffa5 f
S 00000054 ffff8001 f
S 00000058 000080f1 f
S 0000005c 0000016c f
S 00000060 0000017c f
H 0000018c
